/* regfile_vectors.txt */
// ld_en ld_reg ld_size din data_tag dest_en dest_reg dest_size new_tag flush rd_reg_a rd_size_a
// rd_reg_b rd_size_b, then data busy tag for port a and port b; hex, size 0/1/2 is 8/16/32 bit
0 0 0 00000000 00 0 0 0 00 0 0 2 1 1 00000000 0 00 00000000 0 00
0 0 0 00000000 00 0 0 0 00 0 2 0 7 0 00000000 0 00 00000000 0 00
0 0 0 00000000 00 0 0 0 00 0 3 2 4 1 00000000 0 00 00000000 0 00
0 0 0 00000000 00 0 0 0 00 0 5 2 6 2 00000000 0 00 00000000 0 00
1 0 2 12345678 00 0 0 0 00 0 0 2 0 1 00000000 0 00 00000000 0 00
1 0 1 0000abcd 00 0 0 0 00 0 0 2 0 1 12345678 0 00 00005678 0 00
1 4 0 112233ef 00 0 0 0 00 0 0 2 0 0 1234abcd 0 00 000000cd 0 00
1 1 2 a5a5a5a5 00 0 0 0 00 0 0 2 4 0 1234efcd 0 00 000000ef 0 00
1 5 0 7777773c 00 0 0 0 00 0 1 2 1 0 a5a5a5a5 0 00 000000a5 0 00
1 1 0 999999c3 00 0 0 0 00 0 1 2 5 0 a5a53ca5 0 00 0000003c 0 00
0 0 0 00000000 00 0 0 0 00 0 1 1 0 2 00003cc3 0 00 1234efcd 0 00
1 2 2 deadbeef 00 0 0 0 00 0 1 2 2 2 a5a53cc3 0 00 00000000 0 00
0 0 0 00000000 00 1 2 1 15 0 2 2 2 1 deadbeef 0 00 0000beef 0 00
0 0 0 00000000 00 0 0 0 00 0 2 1 2 0 0000beef 1 15 000000ef 1 15
0 0 0 00000000 00 0 0 0 00 0 2 2 6 0 deadbeef 1 15 000000be 1 15
1 2 1 00001234 22 0 0 0 00 0 2 1 2 2 0000beef 1 15 deadbeef 1 15
0 0 0 00000000 00 0 0 0 00 0 2 1 6 0 00001234 1 15 00000012 1 15
1 2 0 00000056 15 0 0 0 00 0 2 2 2 0 dead1234 1 15 00000034 1 15
0 0 0 00000000 00 0 0 0 00 0 2 0 6 0 00000056 0 15 00000012 1 15
1 6 0 00000078 15 0 0 0 00 0 2 1 2 2 00001256 1 15 dead1256 1 15
0 0 0 00000000 00 0 0 0 00 0 2 2 2 1 dead7856 0 15 00007856 0 15
0 0 0 00000000 00 1 3 2 2a 0 3 2 2 0 00000000 0 00 00000056 0 15
1 3 0 00000011 2a 1 3 0 2b 0 3 2 3 0 00000000 1 2a 00000000 1 2a
0 0 0 00000000 00 0 0 0 00 0 3 0 7 0 00000011 1 2b 00000000 1 2a
1 3 0 00000022 2b 0 0 0 00 0 3 1 3 2 00000011 1 2b 00000011 1 2b
0 0 0 00000000 00 0 0 0 00 0 3 0 3 1 00000022 0 2b 00000022 1 2b
0 0 0 00000000 00 1 7 2 40 0 7 2 3 2 00000000 0 00 00000022 1 2b
1 5 2 cafef00d 00 1 5 1 41 0 7 2 5 1 00000000 1 40 00000000 0 00
0 0 0 00000000 00 0 0 0 00 0 5 2 7 0 cafef00d 1 41 00000000 1 2a
0 0 0 00000000 00 0 0 0 00 1 3 2 7 1 00000022 1 2b 00000000 1 40
0 0 0 00000000 00 0 0 0 00 0 3 2 7 1 00000022 0 2b 00000000 0 40
0 0 0 00000000 00 0 0 0 00 0 5 2 2 2 cafef00d 0 41 dead7856 0 15
0 0 0 00000000 00 0 0 0 00 0 7 0 5 0 00000000 0 2a 0000003c 0 00
0 0 0 00000000 00 1 0 2 33 1 0 2 1 2 1234efcd 0 00 a5a53cc3 0 00
0 0 0 00000000 00 0 0 0 00 0 0 2 4 0 1234efcd 0 00 000000ef 0 00
1 6 2 0badf00d 7f 0 0 0 00 0 6 2 1 0 00000000 0 00 000000c3 0 00
0 0 0 00000000 00 1 6 0 7f 0 6 1 6 0 0000f00d 0 00 00000078 0 15
0 0 0 00000000 00 0 0 0 00 0 2 2 6 0 dead7856 1 15 00000078 1 7f
1 6 0 000000aa 7f 0 0 0 00 0 6 2 2 1 0badf00d 0 00 00007856 1 15
0 0 0 00000000 00 0 0 0 00 0 2 2 6 0 deadaa56 0 15 000000aa 0 7f
0 0 0 00000000 00 0 0 0 00 0 0 0 7 2 000000cd 0 00 00000000 0 40
0 0 0 00000000 00 0 0 0 00 0 4 0 5 1 000000ef 0 00 0000f00d 0 41

/* project.f */
+incdir+.
regfile_types_pkg.sv
tag_pkg.sv
operand_decoder.sv
gpr_bank.sv
read_formatter.sv
regfile_top.sv
tb_regfile.sv

/* Bender.yml */
package:
  name: regfile

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - regfile_types_pkg.sv
      - tag_pkg.sv
      - operand_decoder.sv
      - gpr_bank.sv
      - read_formatter.sv
      - regfile_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_regfile.sv

/* tb_regfile.sv */
`default_nettype none

module tb_regfile
    import regfile_types_pkg::*;
    import tag_pkg::*;
();

    localparam int clk_period = 40;
    localparam int num_fields = 20;

    logic          clk;
    logic          rst_n;
    logic          ld_en;
    reg_index_t    ld_reg;
    operand_size_t ld_size;
    word_t         din;
    tag_t          data_tag;
    logic          dest_en;
    reg_index_t    dest_reg;
    operand_size_t dest_size;
    tag_t          new_tag;
    logic          flush;
    reg_index_t    rd_reg_a;
    operand_size_t rd_size_a;
    word_t         rd_data_a;
    pending_t      rd_busy_a;
    tag_t          rd_tag_a;
    reg_index_t    rd_reg_b;
    operand_size_t rd_size_b;
    word_t         rd_data_b;
    pending_t      rd_busy_b;
    tag_t          rd_tag_b;

    // fields of one vector line, in file column order
    logic [31:0] vec [num_fields] = '{default: '0};
    string       vec_lines [$];
    integer      seed = 32'h9984_32f2;
    int          cur_vector = 0;
    bit          vectors_loaded = 1'b0;

    regfile_top dut0 (.*);

    //////////////////////////////////////////////////
    // failure reporting and compares

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    task automatic check_data(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected %h actual %h (vector %0d)",
                     $time, name, expected, actual, cur_vector);
            stop_with_failure();
        end
    endtask

    task automatic check_busy(input string name, input pending_t expected, input pending_t actual);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected %b actual %b (vector %0d)",
                     $time, name, expected, actual, cur_vector);
            stop_with_failure();
        end
    endtask

    task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected %h actual %h (vector %0d)",
                     $time, name, expected, actual, cur_vector);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // vector file

    // comment and blank lines give no fields
    function automatic int parse_fields(input string line);
        return $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       vec[0], vec[1], vec[2], vec[3], vec[4], vec[5], vec[6], vec[7],
                       vec[8], vec[9], vec[10], vec[11], vec[12], vec[13], vec[14],
                       vec[15], vec[16], vec[17], vec[18], vec[19]);
    endfunction

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("regfile_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file regfile_vectors.txt");
            stop_with_failure();
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = parse_fields(line);
                if (n == num_fields) begin
                    vec_lines.push_back(line);
                end else if (n > 0) begin
                    $display("vector line %0d is short, it has %0d of %0d fields",
                             vec_lines.size(), n, num_fields);
                    stop_with_failure();
                end
            end
            $fclose(fd);
            if (vec_lines.size() == 0) begin
                $display("the vector file holds no vectors");
                stop_with_failure();
            end
        end
    endtask

    task automatic drive_vector();
        ld_en     <= vec[0][0];
        ld_reg    <= reg_index_t'(vec[1]);
        ld_size   <= operand_size_t'(vec[2][1:0]);
        // idle lanes carry filler
        din       <= vec[0][0] ? word_t'(vec[3]) : word_t'($random(seed));
        data_tag  <= vec[0][0] ? tag_t'(vec[4]) : tag_t'($random(seed));
        dest_en   <= vec[5][0];
        dest_reg  <= reg_index_t'(vec[6]);
        dest_size <= operand_size_t'(vec[7][1:0]);
        new_tag   <= vec[5][0] ? tag_t'(vec[8]) : tag_t'($random(seed));
        flush     <= vec[9][0];
        rd_reg_a  <= reg_index_t'(vec[10]);
        rd_size_a <= operand_size_t'(vec[11][1:0]);
        rd_reg_b  <= reg_index_t'(vec[12]);
        rd_size_b <= operand_size_t'(vec[13][1:0]);
    endtask

    task automatic check_outputs();
        check_data("rd_data_a", word_t'(vec[14]), rd_data_a);
        check_busy("rd_busy_a", pending_t'(vec[15][0]), rd_busy_a);
        check_tag("rd_tag_a", tag_t'(vec[16]), rd_tag_a);
        check_data("rd_data_b", word_t'(vec[17]), rd_data_b);
        check_busy("rd_busy_b", pending_t'(vec[18][0]), rd_busy_b);
        check_tag("rd_tag_b", tag_t'(vec[19]), rd_tag_b);
    endtask

    //////////////////////////////////////////////////
    // clock, watchdog and main sequence

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        wait (vectors_loaded);
        #((vec_lines.size() + 10) * clk_period * 2);
        $display("timeout: the vectors did not finish in the expected time");
        stop_with_failure();
    end

    initial begin
        rst_n = 1'b0;
        // all-zero fields give idle lanes
        drive_vector();
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < vec_lines.size(); i++) begin
            @(posedge clk);
            cur_vector = i;
            void'(parse_fields(vec_lines[i]));
            drive_vector();
            // just before the edge that applies this line
            #(clk_period - 4);
            check_outputs();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* regfile_top.sv */
`default_nettype none

`include "regfile_settings.svh"

module regfile_top
    import regfile_types_pkg::*;
    import tag_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    // load lane
    input  logic          ld_en,
    input  reg_index_t    ld_reg,
    input  operand_size_t ld_size,
    input  word_t         din,
    input  tag_t          data_tag,
    // destination lane
    input  logic          dest_en,
    input  reg_index_t    dest_reg,
    input  operand_size_t dest_size,
    input  tag_t          new_tag,
    input  logic          flush,
    // read port a
    input  reg_index_t    rd_reg_a,
    input  operand_size_t rd_size_a,
    output word_t         rd_data_a,
    output pending_t      rd_busy_a,
    output tag_t          rd_tag_a,
    // read port b
    input  reg_index_t    rd_reg_b,
    input  operand_size_t rd_size_b,
    output word_t         rd_data_b,
    output pending_t      rd_busy_b,
    output tag_t          rd_tag_b
);

    section_mask_t        ld_masks [`NUM_GPR];
    section_mask_t        dest_masks [`NUM_GPR];
    logic [`E_WIDTH-1:0]  e_vals [`NUM_GPR];
    logic [`HL_WIDTH-1:0] h_vals [`NUM_GPR];
    logic [`HL_WIDTH-1:0] l_vals [`NUM_GPR];
    tag_t                 sec_tags [`NUM_GPR][`SECTIONS];
    pending_t             sec_pending [`NUM_GPR][`SECTIONS];

    //////////////////////////////////////////////////
    // lane decode

    operand_decoder ld_dec (
        .en      (ld_en),
        .reg_sel (ld_reg),
        .size    (ld_size),
        .masks   (ld_masks)
    );

    operand_decoder dest_dec (
        .en      (dest_en),
        .reg_sel (dest_reg),
        .size    (dest_size),
        .masks   (dest_masks)
    );

    //////////////////////////////////////////////////
    // storage

    gpr_bank bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .din         (din),
        .ld_masks    (ld_masks),
        .dest_masks  (dest_masks),
        .data_tag    (data_tag),
        .new_tag     (new_tag),
        .flush       (flush),
        .e_vals      (e_vals),
        .h_vals      (h_vals),
        .l_vals      (l_vals),
        .sec_tags    (sec_tags),
        .sec_pending (sec_pending)
    );

    //////////////////////////////////////////////////
    // read ports

    read_formatter rd_fmt_a (
        .reg_sel     (rd_reg_a),
        .size        (rd_size_a),
        .e_vals      (e_vals),
        .h_vals      (h_vals),
        .l_vals      (l_vals),
        .sec_tags    (sec_tags),
        .sec_pending (sec_pending),
        .data        (rd_data_a),
        .busy        (rd_busy_a),
        .tag         (rd_tag_a)
    );

    read_formatter rd_fmt_b (
        .reg_sel     (rd_reg_b),
        .size        (rd_size_b),
        .e_vals      (e_vals),
        .h_vals      (h_vals),
        .l_vals      (l_vals),
        .sec_tags    (sec_tags),
        .sec_pending (sec_pending),
        .data        (rd_data_b),
        .busy        (rd_busy_b),
        .tag         (rd_tag_b)
    );

endmodule

`default_nettype wire

/* read_formatter.sv */
`default_nettype none

`include "regfile_settings.svh"

module read_formatter
    import regfile_types_pkg::*;
    import tag_pkg::*;
(
    input  reg_index_t           reg_sel,
    input  operand_size_t        size,
    input  logic [`E_WIDTH-1:0]  e_vals [`NUM_GPR],
    input  logic [`HL_WIDTH-1:0] h_vals [`NUM_GPR],
    input  logic [`HL_WIDTH-1:0] l_vals [`NUM_GPR],
    input  tag_t                 sec_tags [`NUM_GPR][`SECTIONS],
    input  pending_t             sec_pending [`NUM_GPR][`SECTIONS],
    output word_t                data,
    output pending_t             busy,
    output tag_t                 tag
);

    reg_index_t    target;
    section_mask_t covered;
    section_mask_t pend_vec;

    //////////////////////////////////////////////////
    // register select

    assign target  = target_reg(size, reg_sel);
    assign covered = size_sections(size, reg_sel);

    //////////////////////////////////////////////////
    // sized value, zero extended

    always_comb begin
        case (size)
            size_32: data = {e_vals[target], h_vals[target], l_vals[target]};
            size_16: data = word_t'({h_vals[target], l_vals[target]});
            size_8: begin
                if (covered[sec_h]) begin
                    data = word_t'(h_vals[target]);
                end else begin
                    data = word_t'(l_vals[target]);
                end
            end
            default: data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // busy and tag

    always_comb begin
        for (int s = 0; s < `SECTIONS; s++) begin
            pend_vec[s] = sec_pending[target][s];
        end
    end

    // any covered section still waiting makes the operand busy
    assign busy = pending_t'(|(covered & pend_vec));

    // report the tag of the lowest covered section
    assign tag = covered[sec_l] ? sec_tags[target][sec_l] : sec_tags[target][sec_h];

endmodule

`default_nettype wire

/* gpr_bank.sv */
`default_nettype none

`include "regfile_settings.svh"

module gpr_bank
    import regfile_types_pkg::*;
    import tag_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  word_t                din,
    input  section_mask_t        ld_masks [`NUM_GPR],
    input  section_mask_t        dest_masks [`NUM_GPR],
    input  tag_t                 data_tag,
    input  tag_t                 new_tag,
    input  logic                 flush,
    output logic [`E_WIDTH-1:0]  e_vals [`NUM_GPR],
    output logic [`HL_WIDTH-1:0] h_vals [`NUM_GPR],
    output logic [`HL_WIDTH-1:0] l_vals [`NUM_GPR],
    output tag_t                 sec_tags [`NUM_GPR][`SECTIONS],
    output pending_t             sec_pending [`NUM_GPR][`SECTIONS]
);

    logic [`E_WIDTH-1:0]  e_din;
    logic [`HL_WIDTH-1:0] l_din;
    logic [`HL_WIDTH-1:0] h_din [`NUM_GPR];

    //////////////////////////////////////////////////
    // load data routing

    assign e_din = din[`WORD_WIDTH-1 -: `E_WIDTH];
    assign l_din = din[`HL_WIDTH-1:0];

    // an 8-bit load to a high byte carries its data in the low byte
    always_comb begin
        for (int r = 0; r < `NUM_GPR; r++) begin
            if (ld_masks[r][sec_l]) begin
                h_din[r] = din[2*`HL_WIDTH-1 -: `HL_WIDTH];
            end else begin
                h_din[r] = l_din;
            end
        end
    end

    //////////////////////////////////////////////////
    // section data registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_GPR; r++) begin
                e_vals[r] <= '0;
                h_vals[r] <= '0;
                l_vals[r] <= '0;
            end
        end else begin
            for (int r = 0; r < `NUM_GPR; r++) begin
                if (ld_masks[r][sec_e]) begin
                    e_vals[r] <= e_din;
                end
                if (ld_masks[r][sec_h]) begin
                    h_vals[r] <= h_din[r];
                end
                if (ld_masks[r][sec_l]) begin
                    l_vals[r] <= l_din;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // rename tags and pending bits

    // flush beats marking, marking beats release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_GPR; r++) begin
                for (int s = 0; s < `SECTIONS; s++) begin
                    sec_tags[r][s]    <= '0;
                    sec_pending[r][s] <= not_pending;
                end
            end
        end else begin
            for (int r = 0; r < `NUM_GPR; r++) begin
                for (int s = 0; s < `SECTIONS; s++) begin
                    if (flush) begin
                        sec_pending[r][s] <= not_pending;
                    end else if (dest_masks[r][s]) begin
                        sec_tags[r][s]    <= new_tag;
                        sec_pending[r][s] <= is_pending;
                    end else if (ld_masks[r][s] && sec_pending[r][s]
                                 && sec_tags[r][s] == data_tag) begin
                        // producer has written back
                        sec_pending[r][s] <= not_pending;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* operand_decoder.sv */
`default_nettype none

`include "regfile_settings.svh"

module operand_decoder
    import regfile_types_pkg::*;
(
    input  logic          en,
    input  reg_index_t    reg_sel,
    input  operand_size_t size,
    output section_mask_t masks [`NUM_GPR]
);

    reg_index_t    target;
    section_mask_t sel_mask;

    //////////////////////////////////////////////////
    // register and section select

    // high-byte names fold onto the low four registers
    assign target = target_reg(size, reg_sel);

    assign sel_mask = size_sections(size, reg_sel);

    //////////////////////////////////////////////////
    // one-hot register expansion

    always_comb begin
        for (int r = 0; r < `NUM_GPR; r++) begin
            masks[r] = '0;
            if (en && target == reg_index_t'(r)) begin
                masks[r] = sel_mask;
            end
        end
    end

endmodule

`default_nettype wire

/* tag_pkg.sv */
`default_nettype none

`include "regfile_settings.svh"

package tag_pkg;

    // rename tag of the producer a section waits on
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // one bit per section, high while the producer is outstanding
    typedef logic pending_t;

    localparam pending_t not_pending = 1'b0;
    localparam pending_t is_pending = 1'b1;

endpackage

`default_nettype wire

/* regfile_types_pkg.sv */
`default_nettype none

`include "regfile_settings.svh"

package regfile_types_pkg;

    // operand size doubles as the access opcode
    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2
    } operand_size_t;

    typedef logic [$clog2(`NUM_GPR)-1:0] reg_index_t;
    typedef logic [`SECTIONS-1:0] section_mask_t;
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // section positions inside a mask
    localparam int sec_l = 0;
    localparam int sec_h = 1;
    localparam int sec_e = 2;

    //////////////////////////////////////////////////
    // size and high-byte aliasing rules

    // sections touched by an access, 8-bit index 4..7 means the h byte
    function automatic section_mask_t size_sections(operand_size_t size, reg_index_t idx);
        section_mask_t m;
        m = '0;
        case (size)
            size_32: m = section_mask_t'(3'b111);
            size_16: m[sec_h] = 1'b1;
            size_8: m[sec_h] = idx[$bits(reg_index_t)-1];
            default: m = '0;
        endcase
        if (size == size_16 || (size == size_8 && !idx[$bits(reg_index_t)-1])) begin
            m[sec_l] = 1'b1;
        end
        return m;
    endfunction

    // ah..bh live in registers 0..3
    function automatic reg_index_t target_reg(operand_size_t size, reg_index_t idx);
        reg_index_t r;
        r = idx;
        if (size == size_8) begin
            r[$bits(reg_index_t)-1] = 1'b0;
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* regfile_settings.svh */
`ifndef REGFILE_SETTINGS_SVH
`define REGFILE_SETTINGS_SVH

// eax ecx edx ebx esp ebp esi edi
`define NUM_GPR 8

// l, h and e sections per register
`define SECTIONS 3

`define WORD_WIDTH 32
`define E_WIDTH 16
`define HL_WIDTH 8

// rename tag width
`define TAG_WIDTH 7

`define NUM_READ 2

`endif
